/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message in the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module dmem_tb \
    && ./obj_dir/Vdmem_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null

grep -q "Simulation PASSED" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* source/data_memory.sv */
`timescale 1ns/10ps

module data_memory (
    input  logic               clk_i,
    input  logic               rst_n_i,         // writes blocked while low
    input  dmem_pkg::addr_t    addr_i,          // byte address, bits 1:0 unused here
    input  dmem_pkg::lane_en_t lane_en_i,       // per lane write enables
    input  dmem_pkg::word_t    lane_wdata_i,    // lane aligned write data
    output dmem_pkg::word_t    rd_word_o        // whole word at the index
);

    // four byte wide banks, one per lane
    logic [dmem_pkg::BYTE_W-1:0] bank_q [dmem_pkg::LANES][dmem_pkg::DMEM_WORDS];

    logic [dmem_pkg::DMEM_INDEX_W-1:0] word_idx;  // upper bits beyond depth dropped

    // byte address to word index, addresses wrap above the depth
    assign word_idx = addr_i[dmem_pkg::DMEM_INDEX_W+1:2];

    // asynchronous read, all lanes at once
    for (genvar lane = 0; lane < dmem_pkg::LANES; lane++) begin : g_rd
        assign rd_word_o[lane*dmem_pkg::BYTE_W +: dmem_pkg::BYTE_W] = bank_q[lane][word_idx];
    end

    // byte enabled write on the rising edge
    always_ff @(posedge clk_i) begin
        if (rst_n_i) begin
            for (int lane = 0; lane < dmem_pkg::LANES; lane++) begin
                if (lane_en_i[lane]) begin
                    bank_q[lane][word_idx] <=
                        lane_wdata_i[lane*dmem_pkg::BYTE_W +: dmem_pkg::BYTE_W];
                end
            end
        end
    end

    // A store presented during reset must leave the addressed word as it
    // was. The value read before the edge is compared with the bank
    // contents one cycle later, so a write leaking through would show up.
    for (genvar lane = 0; lane < dmem_pkg::LANES; lane++) begin : g_chk
        a_no_write_in_reset : assert property (
            @(posedge clk_i)
            !rst_n_i |=>
                bank_q[lane][$past(word_idx)] ===
                $past(rd_word_o[lane*dmem_pkg::BYTE_W +: dmem_pkg::BYTE_W])
        ) else $error("data_memory: lane %0d written during reset", lane);
    end

endmodule

/* source/dmem_pkg.sv */
package dmem_pkg;

    // memory geometry
    localparam int unsigned DMEM_WORDS   = 32768;               // 128 KiB of data memory
    localparam int unsigned DMEM_INDEX_W = $clog2(DMEM_WORDS);  // word index bits
    localparam int unsigned LANES        = 4;                   // byte lanes per word
    localparam int unsigned BYTE_W       = 8;
    localparam int unsigned WORD_W       = LANES * BYTE_W;
    localparam int unsigned ADDR_W       = 32;                  // byte address width

    // data word as seen by the core
    typedef logic [WORD_W-1:0] word_t;

    // byte address, low two bits pick the lane
    typedef logic [ADDR_W-1:0] addr_t;

    // one write enable per byte lane, lane 0 is the lsb
    typedef logic [LANES-1:0] lane_en_t;

    // access size, same encoding as the core's decoder
    typedef enum logic [1:0] {
        SIZE_WORD = 2'b00,  // 32 bit
        SIZE_BYTE = 2'b01,  // 8 bit
        SIZE_HALF = 2'b10   // 16 bit
    } mem_size_e;

endpackage

/* source/dmem_subsystem.sv */
`timescale 1ns/10ps

module dmem_subsystem (
    input  logic                clk_i,
    input  logic                rst_n_i,        // sync, active low
    input  dmem_pkg::addr_t     addr_i,         // byte address
    input  dmem_pkg::mem_size_e size_i,         // word, byte or half
    input  logic                signed_i,       // sign extend loads
    input  logic                write_en_i,     // store strobe
    input  dmem_pkg::word_t     store_data_i,   // store data, right aligned
    output dmem_pkg::word_t     load_data_o,    // load result, same cycle
    output logic                misalign_o      // misaligned access
);

    dmem_pkg::lane_en_t lane_en;    // aligner to memory
    dmem_pkg::word_t    lane_wdata;
    dmem_pkg::word_t    rd_word;    // memory to extractor

    // store side, lane steering and enables
    store_align u_store_align (
        .addr_i       (addr_i),
        .size_i       (size_i),
        .write_en_i   (write_en_i),
        .store_data_i (store_data_i),
        .lane_en_o    (lane_en),
        .lane_wdata_o (lane_wdata)
    );

    // storage, async read and byte write
    data_memory u_data_memory (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .addr_i       (addr_i),
        .lane_en_i    (lane_en),
        .lane_wdata_i (lane_wdata),
        .rd_word_o    (rd_word)
    );

    // load side, also the source of the misalign flag
    load_extract u_load_extract (
        .addr_i      (addr_i),
        .size_i      (size_i),
        .signed_i    (signed_i),
        .rd_word_i   (rd_word),
        .load_data_o (load_data_o),
        .misalign_o  (misalign_o)
    );

endmodule

/* source/load_extract.sv */
`timescale 1ns/10ps

module load_extract (
    input  dmem_pkg::addr_t     addr_i,         // byte address of the load
    input  dmem_pkg::mem_size_e size_i,         // access size
    input  logic                signed_i,       // sign extend when high
    input  dmem_pkg::word_t     rd_word_i,      // raw word from memory
    output dmem_pkg::word_t     load_data_o,    // extended result
    output logic                misalign_o      // misaligned access flag
);

    dmem_pkg::word_t shifted;   // addressed lane moved down to bit 0
    dmem_pkg::word_t extended;  // result before misalign masking
    logic            misalign;
    logic            sign_bit;  // fill bit for the upper part

    // one right shifter serves both byte and half loads
    assign shifted = rd_word_i >> {addr_i[1:0], 3'b000};

    always_comb begin
        misalign = 1'b0;
        sign_bit = 1'b0;
        extended = rd_word_i;                                   // word passes through
        case (size_i)
            dmem_pkg::SIZE_BYTE: begin
                sign_bit = signed_i & shifted[dmem_pkg::BYTE_W-1];
                extended = {{(dmem_pkg::WORD_W - dmem_pkg::BYTE_W){sign_bit}},
                            shifted[dmem_pkg::BYTE_W-1:0]};
            end
            dmem_pkg::SIZE_HALF: begin
                misalign = addr_i[0];
                sign_bit = signed_i & shifted[2*dmem_pkg::BYTE_W-1];
                extended = {{(dmem_pkg::WORD_W - 2*dmem_pkg::BYTE_W){sign_bit}},
                            shifted[2*dmem_pkg::BYTE_W-1:0]};
            end
            default: begin
                misalign = |addr_i[1:0];                        // word needs 4 byte alignment
            end
        endcase
    end

    assign load_data_o = misalign ? '0 : extended;              // no partial data on a fault
    assign misalign_o  = misalign;

    // A flagged load must never hand data to the register file, and a
    // byte load is never flagged. An aligned load brings the addressed
    // byte down to bit 0.
    always_comb begin
        if (!$isunknown({addr_i, size_i, rd_word_i, misalign_o})) begin
            if (misalign_o) begin
                assert (load_data_o == '0 && size_i != dmem_pkg::SIZE_BYTE)
                else $error("load_extract: bad result %h on misaligned load", load_data_o);
            end else begin
                assert (load_data_o[dmem_pkg::BYTE_W-1:0] ==
                        rd_word_i[addr_i[1:0]*dmem_pkg::BYTE_W +: dmem_pkg::BYTE_W])
                else $error("load_extract: wrong low byte %h for address %h",
                            load_data_o[dmem_pkg::BYTE_W-1:0], addr_i);
            end
        end
    end

endmodule

/* source/store_align.sv */
`timescale 1ns/10ps

module store_align (
    input  dmem_pkg::addr_t     addr_i,         // byte address of the store
    input  dmem_pkg::mem_size_e size_i,         // access size
    input  logic                write_en_i,     // store strobe
    input  dmem_pkg::word_t     store_data_i,   // data, right aligned
    output dmem_pkg::lane_en_t  lane_en_o,      // per lane write enables
    output dmem_pkg::word_t     lane_wdata_o    // data steered into lanes
);

    dmem_pkg::lane_en_t lane_sel;   // lanes the access would touch
    logic               misalign;   // access breaks natural alignment

    // Lane selection and data replication. Replicating the low byte or
    // half into every lane means the memory only has to look at the
    // enables, no shifter is needed on the write side.
    always_comb begin
        lane_sel     = '0;
        misalign     = 1'b0;
        lane_wdata_o = store_data_i;
        case (size_i)
            dmem_pkg::SIZE_BYTE: begin
                lane_wdata_o = {dmem_pkg::LANES{store_data_i[dmem_pkg::BYTE_W-1:0]}};
                lane_sel     = dmem_pkg::lane_en_t'(1) << addr_i[1:0];  // one lane
            end
            dmem_pkg::SIZE_HALF: begin
                lane_wdata_o = {2{store_data_i[2*dmem_pkg::BYTE_W-1:0]}};
                misalign     = addr_i[0];                               // odd address
                if (addr_i[1]) begin
                    lane_sel = 4'b1100;                                 // upper half
                end else begin
                    lane_sel = 4'b0011;                                 // lower half
                end
            end
            default: begin                                              // word
                misalign = |addr_i[1:0];
                lane_sel = '1;
            end
        endcase
    end

    // misaligned stores are dropped entirely
    assign lane_en_o = (write_en_i && !misalign) ? lane_sel : '0;

    // Only naturally aligned groups of one, two or four lanes may ever
    // reach the memory. The group must be the one the address and size select.
    always_comb begin
        dmem_pkg::lane_en_t size_mask;  // lanes of the access from lane 0
        case (size_i)
            dmem_pkg::SIZE_BYTE: size_mask = 4'b0001;
            dmem_pkg::SIZE_HALF: size_mask = 4'b0011;
            default:             size_mask = 4'b1111;
        endcase
        if (!$isunknown({lane_en_o, addr_i, size_i, write_en_i}) && lane_en_o != '0) begin
            assert (write_en_i && lane_en_o == (size_mask << addr_i[1:0]) &&
                    lane_en_o inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                      4'b0011, 4'b1100, 4'b1111})
            else $error("store_align: bad lane enable pattern %b", lane_en_o);
        end
    end

endmodule

/* tb.f */
+incdir+tb
source/dmem_pkg.sv
source/store_align.sv
source/load_extract.sv
source/data_memory.sv
source/dmem_subsystem.sv
tb/dmem_tb.sv

/* tb/dmem_vectors.svh */
`ifndef DMEM_VECTORS_SVH
`define DMEM_VECTORS_SVH

// columns: name, in_rst, we, addr, size, sgn, wdata, chk, exp_data, exp_mis
// chk low skips the load data compare, the misalign flag is always compared

localparam int NAME_W = 8 * 12;
localparam int N_VEC  = 43;

localparam dmem_pkg::mem_size_e SW = dmem_pkg::SIZE_WORD;
localparam dmem_pkg::mem_size_e SB = dmem_pkg::SIZE_BYTE;
localparam dmem_pkg::mem_size_e SH = dmem_pkg::SIZE_HALF;

typedef logic [NAME_W-1:0] name_t;

typedef struct packed {
    name_t               name;
    logic                in_rst;    // hold reset during this row
    logic                we;
    dmem_pkg::addr_t     addr;
    dmem_pkg::mem_size_e size;
    logic                sgn;
    dmem_pkg::word_t     wdata;
    logic                chk;
    dmem_pkg::word_t     exp_data;
    logic                exp_mis;
} vec_t;

localparam vec_t VEC_TAB [N_VEC] = '{
    '{"wr_w00",     1'b0, 1'b1, 32'h00, SW, 1'b0, 32'h0a0b_0c0d, 1'b0, 32'h0,         1'b0},
    '{"rd_w00",     1'b0, 1'b0, 32'h00, SW, 1'b0, 32'h0,         1'b1, 32'h0a0b_0c0d, 1'b0},
    '{"wr_w10",     1'b0, 1'b1, 32'h10, SW, 1'b0, 32'hcafe_f00d, 1'b0, 32'h0,         1'b0},
    '{"wr_w14",     1'b0, 1'b1, 32'h14, SW, 1'b0, 32'h1111_2222, 1'b0, 32'h0,         1'b0},
    '{"rd_w10",     1'b0, 1'b0, 32'h10, SW, 1'b0, 32'h0,         1'b1, 32'hcafe_f00d, 1'b0},
    '{"rd_w14",     1'b0, 1'b0, 32'h14, SW, 1'b0, 32'h0,         1'b1, 32'h1111_2222, 1'b0},
    '{"wr_w20",     1'b0, 1'b1, 32'h20, SW, 1'b0, 32'h0,         1'b0, 32'h0,         1'b0},
    '{"wr_b20",     1'b0, 1'b1, 32'h20, SB, 1'b0, 32'hffff_ff81, 1'b0, 32'h0,         1'b0},
    '{"rd_w20a",    1'b0, 1'b0, 32'h20, SW, 1'b0, 32'h0,         1'b1, 32'h0000_0081, 1'b0},
    '{"wr_b21",     1'b0, 1'b1, 32'h21, SB, 1'b0, 32'h0000_007f, 1'b0, 32'h0,         1'b0},
    '{"rd_w20b",    1'b0, 1'b0, 32'h20, SW, 1'b0, 32'h0,         1'b1, 32'h0000_7f81, 1'b0},
    '{"wr_b22",     1'b0, 1'b1, 32'h22, SB, 1'b0, 32'h1234_56a5, 1'b0, 32'h0,         1'b0},
    '{"rd_w20c",    1'b0, 1'b0, 32'h20, SW, 1'b0, 32'h0,         1'b1, 32'h00a5_7f81, 1'b0},
    '{"wr_b23",     1'b0, 1'b1, 32'h23, SB, 1'b0, 32'h0000_003c, 1'b0, 32'h0,         1'b0},
    '{"rd_w20d",    1'b0, 1'b0, 32'h20, SW, 1'b0, 32'h0,         1'b1, 32'h3ca5_7f81, 1'b0},
    '{"lb_20s",     1'b0, 1'b0, 32'h20, SB, 1'b1, 32'h0,         1'b1, 32'hffff_ff81, 1'b0},
    '{"lb_20u",     1'b0, 1'b0, 32'h20, SB, 1'b0, 32'h0,         1'b1, 32'h0000_0081, 1'b0},
    '{"lb_21s",     1'b0, 1'b0, 32'h21, SB, 1'b1, 32'h0,         1'b1, 32'h0000_007f, 1'b0},
    '{"lb_21u",     1'b0, 1'b0, 32'h21, SB, 1'b0, 32'h0,         1'b1, 32'h0000_007f, 1'b0},
    '{"lb_22s",     1'b0, 1'b0, 32'h22, SB, 1'b1, 32'h0,         1'b1, 32'hffff_ffa5, 1'b0},
    '{"lb_22u",     1'b0, 1'b0, 32'h22, SB, 1'b0, 32'h0,         1'b1, 32'h0000_00a5, 1'b0},
    '{"lb_23s",     1'b0, 1'b0, 32'h23, SB, 1'b1, 32'h0,         1'b1, 32'h0000_003c, 1'b0},
    '{"lh_20s",     1'b0, 1'b0, 32'h20, SH, 1'b1, 32'h0,         1'b1, 32'h0000_7f81, 1'b0},
    '{"lh_22u",     1'b0, 1'b0, 32'h22, SH, 1'b0, 32'h0,         1'b1, 32'h0000_3ca5, 1'b0},
    '{"wr_h16",     1'b0, 1'b1, 32'h16, SH, 1'b0, 32'h1234_beef, 1'b0, 32'h0,         1'b0},
    '{"lh_16s",     1'b0, 1'b0, 32'h16, SH, 1'b1, 32'h0,         1'b1, 32'hffff_beef, 1'b0},
    '{"lh_16u",     1'b0, 1'b0, 32'h16, SH, 1'b0, 32'h0,         1'b1, 32'h0000_beef, 1'b0},
    '{"rd_w14b",    1'b0, 1'b0, 32'h14, SW, 1'b0, 32'h0,         1'b1, 32'hbeef_2222, 1'b0},
    '{"lh_21",      1'b0, 1'b0, 32'h21, SH, 1'b1, 32'h0,         1'b1, 32'h0,         1'b1},
    '{"lw_22",      1'b0, 1'b0, 32'h22, SW, 1'b0, 32'h0,         1'b1, 32'h0,         1'b1},
    '{"lw_13",      1'b0, 1'b0, 32'h13, SW, 1'b0, 32'h0,         1'b1, 32'h0,         1'b1},
    '{"sw_12",      1'b0, 1'b1, 32'h12, SW, 1'b0, 32'hffff_ffff, 1'b1, 32'h0,         1'b1},
    '{"sh_15",      1'b0, 1'b1, 32'h15, SH, 1'b0, 32'hffff_ffff, 1'b1, 32'h0,         1'b1},
    '{"rd_w10b",    1'b0, 1'b0, 32'h10, SW, 1'b0, 32'h0,         1'b1, 32'hcafe_f00d, 1'b0},
    '{"rd_w14c",    1'b0, 1'b0, 32'h14, SW, 1'b0, 32'h0,         1'b1, 32'hbeef_2222, 1'b0},
    '{"sw_10_old",  1'b0, 1'b1, 32'h10, SW, 1'b0, 32'h5555_aaaa, 1'b1, 32'hcafe_f00d, 1'b0},
    '{"rd_w10_new", 1'b0, 1'b0, 32'h10, SW, 1'b0, 32'h0,         1'b1, 32'h5555_aaaa, 1'b0},
    '{"sb_11_old",  1'b0, 1'b1, 32'h11, SB, 1'b0, 32'h0000_0066, 1'b1, 32'h0000_00aa, 1'b0},
    '{"rd_w10c",    1'b0, 1'b0, 32'h10, SW, 1'b0, 32'h0,         1'b1, 32'h5555_66aa, 1'b0},
    '{"rst_sw10",   1'b1, 1'b1, 32'h10, SW, 1'b0, 32'hdead_beef, 1'b1, 32'h5555_66aa, 1'b0},
    '{"rd_w10_rst", 1'b0, 1'b0, 32'h10, SW, 1'b0, 32'h0,         1'b1, 32'h5555_66aa, 1'b0},
    '{"wr_wrap",    1'b0, 1'b1, 32'h0002_0030, SW, 1'b0, 32'h0bad_c0de, 1'b0, 32'h0, 1'b0},
    '{"rd_wrap",    1'b0, 1'b0, 32'h30, SW, 1'b0, 32'h0,         1'b1, 32'h0bad_c0de, 1'b0}
};

`endif

/* tb/dmem_tb.sv */
`timescale 1ns/10ps

module dmem_tb;

    localparam int RST_CYCLES = 5;
    localparam int N_RAND     = 400;
    localparam int WIN_BYTES  = 64;                         // random address window
    localparam dmem_pkg::addr_t WIN_BASE = 32'h0000_0200;

    `include "dmem_vectors.svh"

    localparam int CYCLE_LIMIT = RST_CYCLES + N_VEC + WIN_BYTES / 4 + N_RAND + 100;

    logic                clk = 1'b0;
    logic                rst_n;
    dmem_pkg::addr_t     addr;
    dmem_pkg::mem_size_e acc_size;
    logic                sgn;
    logic                we;
    dmem_pkg::word_t     wdata;
    dmem_pkg::word_t     load_data;
    logic                misalign;

    int          err_cnt   = 0;
    int          chk_cnt   = 0;
    int          cycle_cnt = 0;
    logic [31:0] lfsr_q    = 32'hea40_bcef;
    logic [7:0]  shadow [WIN_BYTES];                        // byte image of the window

    dmem_subsystem u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .addr_i       (addr),
        .size_i       (acc_size),
        .signed_i     (sgn),
        .write_en_i   (we),
        .store_data_i (wdata),
        .load_data_o  (load_data),
        .misalign_o   (misalign)
    );

    always #2 clk = ~clk;                                   // 4 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_word(input name_t name, input dmem_pkg::word_t exp_val,
                              input dmem_pkg::word_t act_val);
        chk_cnt++;
        if (act_val !== exp_val) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic check_flag(input name_t name, input logic exp_val, input logic act_val);
        chk_cnt++;
        if (act_val !== exp_val) begin
            err_cnt++;
            $display("ERR %s expected %b actual %b", name, exp_val, act_val);
        end
    endtask

    // drive on the falling edge, outputs settle 1 ns later
    task automatic apply_access(input logic rst_act, input logic we_v, input dmem_pkg::addr_t a,
                                input dmem_pkg::mem_size_e sz, input logic sgn_v,
                                input dmem_pkg::word_t d);
        @(negedge clk);
        rst_n    = !rst_act;
        we       = we_v;
        addr     = a;
        acc_size = sz;
        sgn      = sgn_v;
        wdata    = d;
        #1;
    endtask

    task automatic apply_random();
        logic [31:0]         r_we;
        logic [31:0]         r_off;
        logic [31:0]         r_sz;
        logic [31:0]         r_sgn;
        logic [31:0]         r_data;
        dmem_pkg::mem_size_e sz;
        dmem_pkg::word_t     exp_val;
        logic                mis;
        int unsigned         off;
        draw_bits(1, r_we);
        draw_bits(6, r_off);
        draw_bits(2, r_sz);
        draw_bits(1, r_sgn);
        draw_bits(32, r_data);
        off = r_off[5:0];
        case (r_sz[1:0])
            2'd1:    sz = dmem_pkg::SIZE_BYTE;
            2'd2:    sz = dmem_pkg::SIZE_HALF;
            default: sz = dmem_pkg::SIZE_WORD;
        endcase
        mis = (sz == dmem_pkg::SIZE_HALF) ? r_off[0] :
              (sz == dmem_pkg::SIZE_WORD) ? |r_off[1:0] : 1'b0;
        exp_val = '0;                                       // misaligned loads return zero
        if (!mis) begin
            case (sz)
                dmem_pkg::SIZE_BYTE: exp_val = {{24{r_sgn[0] & shadow[off][7]}}, shadow[off]};
                dmem_pkg::SIZE_HALF: exp_val = {{16{r_sgn[0] & shadow[off + 1][7]}},
                                                shadow[off + 1], shadow[off]};
                default:             exp_val = {shadow[off + 3], shadow[off + 2],
                                                shadow[off + 1], shadow[off]};
            endcase
        end
        apply_access(1'b0, r_we[0], {WIN_BASE[31:6], r_off[5:0]}, sz, r_sgn[0], r_data);
        check_word("random", exp_val, load_data);
        check_flag("random_mis", mis, misalign);
        // store lands at the coming edge, after this cycle's load
        if (r_we[0] && !mis) begin
            shadow[off] = r_data[7:0];
            if (sz != dmem_pkg::SIZE_BYTE) begin
                shadow[off + 1] = r_data[15:8];
            end
            if (sz == dmem_pkg::SIZE_WORD) begin
                shadow[off + 2] = r_data[23:16];
                shadow[off + 3] = r_data[31:24];
            end
        end
    endtask

    initial begin
        logic [31:0] fill;
        rst_n    = 1'b0;
        we       = 1'b1;                                    // store attempt inside reset
        addr     = '0;
        acc_size = dmem_pkg::SIZE_WORD;
        sgn      = 1'b0;
        wdata    = 32'hdead_beef;
        repeat (RST_CYCLES) @(posedge clk);
        for (int i = 0; i < N_VEC; i++) begin
            apply_access(VEC_TAB[i].in_rst, VEC_TAB[i].we, VEC_TAB[i].addr,
                         VEC_TAB[i].size, VEC_TAB[i].sgn, VEC_TAB[i].wdata);
            if (VEC_TAB[i].chk) begin
                check_word(VEC_TAB[i].name, VEC_TAB[i].exp_data, load_data);
            end
            check_flag(VEC_TAB[i].name, VEC_TAB[i].exp_mis, misalign);
        end
        for (int w = 0; w < WIN_BYTES / 4; w++) begin        // known contents first
            draw_bits(32, fill);
            apply_access(1'b0, 1'b1, WIN_BASE + dmem_pkg::addr_t'(w * 4),
                         dmem_pkg::SIZE_WORD, 1'b0, fill);
            check_flag("fill", 1'b0, misalign);
            for (int b = 0; b < 4; b++) begin
                shadow[w * 4 + b] = fill[b * 8 +: 8];
            end
        end
        for (int n = 0; n < N_RAND; n++) begin
            apply_random();
        end
        @(negedge clk);
        we = 1'b0;
        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
